//--- snes_cart_ctrl.f
cart_pkg.sv
snes_bus_sync.sv
snes_alive_timer.sv
mcu_access_fsm.sv
rom_port.sv
snes_cart_ctrl.sv
psram_model.sv
tb_snes_cart_ctrl.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_snes_cart_ctrl \
  -f snes_cart_ctrl.f -o tb_snes_cart_ctrl > build.log 2>&1 &&
  ./obj_dir/tb_snes_cart_ctrl > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; echo "run.sh: build or simulation error"; exit 1; }
cat sim.log
grep -q "^Simulation PASSED$" sim.log || exit 1

//--- tb_snes_cart_ctrl.sv
`timescale 1ns/100ps

module tb_snes_cart_ctrl;

  import cart_pkg::*;

  localparam int MEM_AW     = 10;
  localparam int MEM_WORDS  = 2**MEM_AW;
  localparam int N_WR       = 16;
  localparam int N_RD_EXTRA = 8;
  localparam int N_CONSOLE  = 20;
  localparam int N_MCU_BUSY = 6;
  localparam int LOW_LEN    = 12;   // Console clock phases in CLK2 cycles
  localparam int HIGH_LEN   = 12;
  localparam int ACC_CYCLES = 60;   // Longest wait for one MCU access
  localparam int DEAD_WAIT  = int'(SNES_DEAD_TIMEOUT) + ACC_CYCLES;
  localparam int WATCHDOG_CYCLES = 100 + MEM_WORDS + (2*N_WR + N_RD_EXTRA + N_MCU_BUSY + 2)
                                   * ACC_CYCLES + (N_CONSOLE + 6) * (LOW_LEN + HIGH_LEN)
                                   + DEAD_WAIT;
  localparam logic [SNES_ADDR_W-1:0] ROM_BASE = 24'h40_0000;  // A22 set

  logic CLK2;
  logic reset;
  logic [SNES_ADDR_W-1:0] snes_addr_in;
  logic [BYTE_W-1:0]      snes_data_in;
  logic snes_rd_n_in;
  logic snes_wr_n_in;
  logic snes_cpu_clk_in;
  logic [BYTE_W-1:0]      snes_data_out;
  logic snes_data_oe;
  mcu_req_t               mcu_req;
  logic                   mcu_rdy;
  logic [BYTE_W-1:0]      mcu_rdata;
  rom_bus_t               rom;
  logic [ROM_DATA_W-1:0]  rom_dq_in;
  logic                   load;
  logic [MEM_AW-1:0]      load_idx;
  logic [ROM_DATA_W-1:0]  load_word;

  logic [ROM_DATA_W-1:0]  shadow [MEM_WORDS];
  logic [SNES_ADDR_W-1:0] cur_addr;
  logic [31:0]            lfsr_state = 32'h775fd6f3;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int we_cycles = 0;

  snes_cart_ctrl u_snes_cart_ctrl (.*);

  psram_model #(.MEM_AW(MEM_AW)) u_psram (
    .CLK2 (CLK2), .rom (rom), .load (load), .load_idx (load_idx),
    .load_word (load_word), .dq (rom_dq_in)
  );

  initial begin
    CLK2 = 1'b0;
    forever #10 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};  // Taps 32, 22, 2, 1
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [SNES_ADDR_W-1:0] random_rom_addr();
    logic [31:0] r;
    r = random_bits(MEM_AW + 1);
    return ROM_BASE | r[SNES_ADDR_W-1:0];
  endfunction

  // Odd byte address on the low lane
  function automatic logic [BYTE_W-1:0] expected_byte(input logic [SNES_ADDR_W-1:0] addr);
    logic [ROM_DATA_W-1:0] w;
    w = shadow[addr[MEM_AW:1]];
    return addr[0] ? w[BYTE_W-1:0] : w[ROM_DATA_W-1:BYTE_W];
  endfunction

  task automatic write_shadow(input logic [SNES_ADDR_W-1:0] addr, input logic [BYTE_W-1:0] d);
    if (addr[0]) begin
      shadow[addr[MEM_AW:1]][BYTE_W-1:0] = d;
    end else begin
      shadow[addr[MEM_AW:1]][ROM_DATA_W-1:BYTE_W] = d;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (errors == err_start) ? "ok" : "failing", errors - err_start);
  endtask

  // One request pulse, then wait for mcu_rdy to come back
  task automatic mcu_access(input mcu_op_e op, input logic [SNES_ADDR_W-1:0] addr,
                            input logic [BYTE_W-1:0] wdata, input int max_cycles,
                            output logic [BYTE_W-1:0] rdata, output int latency);
    int n;
    n = 0;
    @(posedge CLK2);
    #2;
    cur_addr      = addr;
    mcu_req.addr  = addr;
    mcu_req.wdata = wdata;
    mcu_req.rrq   = (op == OP_READ);
    mcu_req.wrq   = (op == OP_WRITE);
    @(posedge CLK2);
    #2;
    mcu_req.rrq = 1'b0;
    mcu_req.wrq = 1'b0;
    @(negedge CLK2);
    check_true(!mcu_rdy, "mcu_rdy stayed high after a request");
    while (!mcu_rdy && n < max_cycles) begin
      @(negedge CLK2);
      n++;
    end
    check_true(mcu_rdy, "MCU access never finished, mcu_rdy stayed low");
    rdata   = mcu_rdata;
    latency = n;
  endtask

  // Clock falls, address and read go out, check late in the high phase
  task automatic console_read(input logic [SNES_ADDR_W-1:0] addr);
    @(posedge CLK2);
    #2;
    snes_cpu_clk_in = 1'b0;
    snes_addr_in    = addr;
    snes_rd_n_in    = 1'b0;
    repeat (LOW_LEN) @(posedge CLK2);
    #2;
    snes_cpu_clk_in = 1'b1;
    repeat (HIGH_LEN - 2) @(negedge CLK2);
    check_value("snes_data_oe", 32'(snes_data_oe), 32'd1);
    check_value("snes_data_out", 32'(snes_data_out), 32'(expected_byte(addr)));
  endtask

  ////////////////////////////////////////////////////////////
  // Checks on the PSRAM pins
  ////////////////////////////////////////////////////////////

  always @(negedge CLK2) begin
    if (!reset && !rom.we_n) we_cycles++;
  end

  assert property (@(negedge CLK2) disable iff (reset)
    !rom.we_n |-> (rom.addr == cur_addr[SNES_ADDR_W-1:1]) && (rom.ble_n == !cur_addr[0])
                  && (rom.bhe_n == cur_addr[0]))
  else begin
    errors++;
    $display("** Error: rom addr/bhe_n/ble_n = %h/%h/%h, expected %h/%h/%h at %0t",
             rom.addr, rom.bhe_n, rom.ble_n, cur_addr[SNES_ADDR_W-1:1], cur_addr[0],
             !cur_addr[0], $time);
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [SNES_ADDR_W-1:0] addr;
    logic [SNES_ADDR_W-1:0] written [$];
    logic [SNES_ADDR_W-1:0] console_addrs [N_CONSOLE];
    logic [BYTE_W-1:0]      d;
    logic [BYTE_W-1:0]      rdata;
    logic [31:0]            r;
    int lat;
    int e0;
    int we0;
    reset = 1'b1;
    snes_addr_in = '0;
    snes_data_in = '0;
    snes_rd_n_in = 1'b1;
    snes_wr_n_in = 1'b1;
    snes_cpu_clk_in = 1'b0;  // Console silent, so dead
    mcu_req   = '0;
    cur_addr  = '0;
    load      = 1'b0;
    load_idx  = '0;
    load_word = '0;
    repeat (5) @(posedge CLK2);
    #2 reset = 1'b0;

    e0 = errors;
    @(negedge CLK2);
    check_value("mcu_rdy", 32'(mcu_rdy), 32'd1);
    check_value("rom.we_n", 32'(rom.we_n), 32'd1);
    check_value("rom.bhe_n", 32'(rom.bhe_n), 32'd1);
    check_value("rom.ble_n", 32'(rom.ble_n), 32'd1);
    check_value("rom.dq_oe", 32'(rom.dq_oe), 32'd0);
    check_value("snes_data_oe", 32'(snes_data_oe), 32'd0);
    end_test("reset state", e0);

    for (int i = 0; i < MEM_WORDS; i++) begin  // Preload model and shadow
      r = random_bits(ROM_DATA_W);
      @(posedge CLK2);
      #2;
      load      = 1'b1;
      load_idx  = i[MEM_AW-1:0];
      load_word = r[ROM_DATA_W-1:0];
      shadow[i] = r[ROM_DATA_W-1:0];
    end
    @(posedge CLK2);
    #2 load = 1'b0;

    e0 = errors;
    for (int i = 0; i < N_WR; i++) begin
      addr = random_rom_addr();
      r    = random_bits(BYTE_W);
      d    = r[BYTE_W-1:0];
      we0  = we_cycles;
      mcu_access(OP_WRITE, addr, d, ACC_CYCLES, rdata, lat);
      write_shadow(addr, d);
      written.push_back(addr);
      check_value("we_n low cycles", 32'(we_cycles - we0), 32'(ROM_CYCLE_LEN) + 32'd1);
      check_value("psram word", 32'(u_psram.mem[addr[MEM_AW:1]]),
                  32'(shadow[addr[MEM_AW:1]]));
    end
    end_test("MCU writes, console dead", e0);

    e0 = errors;
    for (int i = 0; i < N_RD_EXTRA; i++) written.push_back(random_rom_addr());
    foreach (written[i]) begin
      mcu_access(OP_READ, written[i], '0, ACC_CYCLES, rdata, lat);
      check_value("mcu_rdata", 32'(rdata), 32'(expected_byte(written[i])));
    end
    end_test("MCU reads", e0);

    e0 = errors;
    foreach (console_addrs[i]) console_addrs[i] = random_rom_addr();
    fork
      begin
        foreach (console_addrs[i]) console_read(console_addrs[i]);
      end
      begin
        for (int k = 0; k < N_MCU_BUSY; k++) begin
          addr = random_rom_addr();
          r    = random_bits(BYTE_W);
          if (k % 2 == 0) begin
            mcu_access(OP_READ, addr, '0, ACC_CYCLES, rdata, lat);
            check_value("mcu_rdata", 32'(rdata), 32'(expected_byte(addr)));
          end else begin
            mcu_access(OP_WRITE, addr, r[BYTE_W-1:0], ACC_CYCLES, rdata, lat);
            write_shadow(addr, r[BYTE_W-1:0]);
          end
        end
      end
    join
    end_test("console ROM reads with MCU traffic", e0);

    e0 = errors;
    @(posedge CLK2);
    #2;
    snes_cpu_clk_in = 1'b0;  // Console stops
    snes_rd_n_in    = 1'b1;
    repeat (10) @(posedge CLK2);
    addr = random_rom_addr();
    mcu_access(OP_READ, addr, '0, DEAD_WAIT, rdata, lat);
    check_value("mcu_rdata", 32'(rdata), 32'(expected_byte(addr)));
    check_true(lat > int'(SNES_DEAD_TIMEOUT) - 20, "read finished before the console was dead");
    addr = random_rom_addr();
    fork
      mcu_access(OP_READ, addr, '0, ACC_CYCLES, rdata, lat);
      begin
        repeat (3) @(posedge CLK2);
        #2 snes_cpu_clk_in = 1'b1;  // Console returns mid-access
        repeat (HIGH_LEN) @(posedge CLK2);
        for (int i = 0; i < 3; i++) console_read(console_addrs[i]);
      end
    join
    check_value("mcu_rdata", 32'(rdata), 32'(expected_byte(addr)));
    check_true(lat > 2 * (int'(ROM_CYCLE_LEN) + 1), "restarted read ended without a restart");
    end_test("console dead and revived", e0);

    $display("%0d tests, %0d failing, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- psram_model.sv
`timescale 1ns/100ps

module psram_model #(
  parameter int MEM_AW = 10
) (
  input  logic                            CLK2,
  input  cart_pkg::rom_bus_t              rom,
  input  logic                            load,
  input  logic [MEM_AW-1:0]               load_idx,
  input  logic [cart_pkg::ROM_DATA_W-1:0] load_word,
  output logic [cart_pkg::ROM_DATA_W-1:0] dq
);

  import cart_pkg::*;

  logic [ROM_DATA_W-1:0] mem [2**MEM_AW];
  logic [MEM_AW-1:0]     idx;

  assign idx = rom.addr[MEM_AW-1:0];  // Upper word bits alias
  assign dq  = mem[idx];              // Asynchronous read

  // Preload port, then byte-lane writes
  always @(posedge CLK2) begin
    if (load) begin
      mem[load_idx] <= load_word;
    end else if (!rom.we_n && rom.dq_oe) begin
      if (!rom.bhe_n) mem[idx][ROM_DATA_W-1:BYTE_W] <= rom.dq_out[ROM_DATA_W-1:BYTE_W];
      if (!rom.ble_n) mem[idx][BYTE_W-1:0] <= rom.dq_out[BYTE_W-1:0];
    end
  end

endmodule

//--- snes_cart_ctrl.sv
`timescale 1ns/100ps

module snes_cart_ctrl (
  input  logic                             CLK2,
  input  logic                             reset,
  // Console pins, asynchronous
  input  logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic [cart_pkg::BYTE_W-1:0]      snes_data_in,
  input  logic                             snes_rd_n_in,
  input  logic                             snes_wr_n_in,
  input  logic                             snes_cpu_clk_in,
  output logic [cart_pkg::BYTE_W-1:0]      snes_data_out,
  output logic                             snes_data_oe,
  // MCU handshake
  input  cart_pkg::mcu_req_t               mcu_req,
  output logic                             mcu_rdy,
  output logic [cart_pkg::BYTE_W-1:0]      mcu_rdata,
  // PSRAM
  output cart_pkg::rom_bus_t               rom,
  input  logic [cart_pkg::ROM_DATA_W-1:0]  rom_dq_in
);

  import cart_pkg::*;

  snes_bus_t     bus;
  snes_strobes_t strobes;
  mcu_grant_t    grant;

  logic snes_dead;
  logic alive_strobe;
  logic free_slot;

  snes_bus_sync u_snes_bus_sync (
    .CLK2            (CLK2),
    .snes_addr_in    (snes_addr_in),
    .snes_data_in    (snes_data_in),
    .snes_rd_n_in    (snes_rd_n_in),
    .snes_wr_n_in    (snes_wr_n_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (bus),
    .strobes         (strobes)
  );

  snes_alive_timer u_snes_alive_timer (
    .CLK2         (CLK2),
    .reset        (reset),
    .bus          (bus),
    .snes_dead    (snes_dead),
    .alive_strobe (alive_strobe)
  );

  mcu_access_fsm u_mcu_access_fsm (
    .CLK2         (CLK2),
    .reset        (reset),
    .req          (mcu_req),
    .free_slot    (free_slot),
    .snes_dead    (snes_dead),
    .alive_strobe (alive_strobe),
    .mcu_rdy      (mcu_rdy),
    .grant        (grant)
  );

  rom_port u_rom_port (
    .CLK2          (CLK2),
    .reset         (reset),
    .bus           (bus),
    .strobes       (strobes),
    .grant         (grant),
    .wdata         (mcu_req.wdata),  // MCU holds it until ready
    .rom_dq_in     (rom_dq_in),
    .rom           (rom),
    .free_slot     (free_slot),
    .mcu_rdata     (mcu_rdata),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

endmodule

//--- rom_port.sv
`timescale 1ns/100ps

module rom_port (
  input  logic                            CLK2,
  input  logic                            reset,
  input  cart_pkg::snes_bus_t             bus,
  input  cart_pkg::snes_strobes_t         strobes,
  input  cart_pkg::mcu_grant_t            grant,
  input  logic [cart_pkg::BYTE_W-1:0]     wdata,
  input  logic [cart_pkg::ROM_DATA_W-1:0] rom_dq_in,
  output cart_pkg::rom_bus_t              rom,
  output logic                            free_slot,
  output logic [cart_pkg::BYTE_W-1:0]     mcu_rdata,
  output logic [cart_pkg::BYTE_W-1:0]     snes_data_out,
  output logic                            snes_data_oe
);

  import cart_pkg::*;

  logic rom_hit;
  logic snes_rom_rd;
  logic free_strobe;
  logic mcu_wr;
  logic mcu_rd;
  logic lane_en;
  logic addr0;

  logic [SNES_ADDR_W-1:0] sel_addr;

  ////////////////////////////////////////////////////////////
  // ROM window and free slots
  ////////////////////////////////////////////////////////////

  // Fixed decode: A15 or A22 set means ROM
  assign rom_hit     = bus.addr[15] | bus.addr[22];
  assign snes_rom_rd = ~bus.rd_n & rom_hit;

  // Cycle that starts outside ROM leaves the PSRAM idle
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= strobes.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = strobes.cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////
  // PSRAM side
  ////////////////////////////////////////////////////////////

  assign mcu_wr   = grant.active && (grant.op == OP_WRITE);
  assign mcu_rd   = grant.active && (grant.op == OP_READ);
  assign sel_addr = grant.active ? grant.addr : bus.addr;  // MCU wins while granted
  assign addr0    = sel_addr[0];
  assign lane_en  = grant.active | snes_rom_rd;

  always_comb begin
    rom.addr   = sel_addr[SNES_ADDR_W-1:1];
    rom.we_n   = ~mcu_wr;
    rom.ble_n  = ~(lane_en & addr0);   // Odd byte on the low lane
    rom.bhe_n  = ~(lane_en & ~addr0);
    rom.dq_out = {wdata, wdata};       // Lane enables pick the byte
    rom.dq_oe  = mcu_wr;
  end

  // Last sample before END is the one the MCU sees
  always_ff @(posedge CLK2) begin
    if (mcu_rd) begin
      mcu_rdata <= addr0 ? rom_dq_in[BYTE_W-1:0] : rom_dq_in[ROM_DATA_W-1:BYTE_W];
    end
  end

  ////////////////////////////////////////////////////////////
  // Console read path
  ////////////////////////////////////////////////////////////

  assign snes_data_out = bus.addr[0] ? rom_dq_in[BYTE_W-1:0]
                                     : rom_dq_in[ROM_DATA_W-1:BYTE_W];
  assign snes_data_oe  = snes_rom_rd;

endmodule

//--- mcu_access_fsm.sv
`timescale 1ns/100ps

module mcu_access_fsm (
  input  logic                 CLK2,
  input  logic                 reset,
  input  cart_pkg::mcu_req_t   req,
  input  logic                 free_slot,
  input  logic                 snes_dead,
  input  logic                 alive_strobe,
  output logic                 mcu_rdy,
  output cart_pkg::mcu_grant_t grant
);

  import cart_pkg::*;

  access_state_e state;

  logic rd_pend;
  logic wr_pend;
  logic access_end;

  logic [SNES_ADDR_W-1:0]         addr_r;
  logic [$bits(ROM_CYCLE_LEN)-1:0] delay_cnt;

  assign access_end = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  ////////////////////////////////////////////////////////////
  // Request latch and ready handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (req.rrq && mcu_rdy) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (req.wrq && mcu_rdy) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;  // Seen the cycle after END
    end
  end

  // Address held for the whole access
  always_ff @(posedge CLK2) begin
    if ((req.rrq || req.wrq) && mcu_rdy) begin
      addr_r <= req.addr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= ST_IDLE;
    end else if (alive_strobe) begin
      // Console came back, restart from idle with the request kept
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state     <= ST_MCU_RD_ADDR;
              delay_cnt <= ROM_CYCLE_LEN;
            end else if (wr_pend) begin
              state     <= ST_MCU_WR_ADDR;
              delay_cnt <= ROM_CYCLE_LEN;
            end
          end
        end
        ST_MCU_RD_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= ST_MCU_RD_END;
        end
        ST_MCU_WR_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= ST_MCU_WR_END;
        end
        ST_MCU_RD_END, ST_MCU_WR_END: begin
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Bus ownership only during the ADDR states
  always_comb begin
    grant.active = (state == ST_MCU_RD_ADDR) || (state == ST_MCU_WR_ADDR);
    grant.op     = (state == ST_MCU_WR_ADDR) ? OP_WRITE : OP_READ;
    grant.addr   = addr_r;
  end

endmodule

//--- snes_alive_timer.sv
`timescale 1ns/100ps

module snes_alive_timer (
  input  logic                CLK2,
  input  logic                reset,
  input  cart_pkg::snes_bus_t bus,
  output logic                snes_dead,
  output logic                alive_strobe
);

  import cart_pkg::*;

  logic [DEAD_CNT_W-1:0] dead_cnt;

  // Low-time counter, held at full scale once it gets there
  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
    end else if (bus.cpu_clk) begin
      dead_cnt <= '0;
    end else if (dead_cnt != '1) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Dead flag and revival pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_dead    <= 1'b1;  // Never seen counts as dead
      alive_strobe <= 1'b0;
    end else begin
      alive_strobe <= 1'b0;
      if (bus.cpu_clk) begin
        snes_dead    <= 1'b0;
        alive_strobe <= snes_dead;  // First high sample only
      end else if (dead_cnt >= SNES_DEAD_TIMEOUT) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

//--- snes_bus_sync.sv
`timescale 1ns/100ps

module snes_bus_sync (
  input  logic                             CLK2,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic [cart_pkg::BYTE_W-1:0]      snes_data_in,
  input  logic                             snes_rd_n_in,
  input  logic                             snes_wr_n_in,
  input  logic                             snes_cpu_clk_in,
  output cart_pkg::snes_bus_t              bus,
  output cart_pkg::snes_strobes_t          strobes
);

  import cart_pkg::*;

  ////////////////////////////////////////////////////////////
  // Oversampling registers
  ////////////////////////////////////////////////////////////

  logic [SYNC_DEPTH-1:0] rd_r;
  logic [SYNC_DEPTH-1:0] wr_r;
  logic [SYNC_DEPTH-3:0] clk_r;  // CPU clock needs a shorter history

  logic [ADDR_PIPE_DEPTH-1:0][SNES_ADDR_W-1:0] addr_r;
  logic [ADDR_PIPE_DEPTH-1:0][BYTE_W-1:0]      data_r;

  // Pairwise ANDed history, a single-sample spike cannot form a run
  logic [SYNC_DEPTH-3:0] rd_hist;
  logic [SYNC_DEPTH-3:0] wr_hist;
  logic [SYNC_DEPTH-5:0] clk_hist;

  always_ff @(posedge CLK2) begin
    rd_r   <= {rd_r[SYNC_DEPTH-2:0], snes_rd_n_in};
    wr_r   <= {wr_r[SYNC_DEPTH-2:0], snes_wr_n_in};
    clk_r  <= {clk_r[SYNC_DEPTH-4:0], snes_cpu_clk_in};
    addr_r <= {addr_r[ADDR_PIPE_DEPTH-2:0], snes_addr_in};
    data_r <= {data_r[ADDR_PIPE_DEPTH-2:0], snes_data_in};
  end

  assign rd_hist  = rd_r[SYNC_DEPTH-2:1] & rd_r[SYNC_DEPTH-1:2];
  assign wr_hist  = wr_r[SYNC_DEPTH-2:1] & wr_r[SYNC_DEPTH-1:2];
  assign clk_hist = clk_r[SYNC_DEPTH-4:1] & clk_r[SYNC_DEPTH-3:2];

  ////////////////////////////////////////////////////////////
  // Levels
  ////////////////////////////////////////////////////////////

  always_comb begin
    bus.rd_n    = rd_r[2] & rd_r[1];
    bus.wr_n    = wr_r[2] & wr_r[1];
    bus.cpu_clk = clk_r[2] & clk_r[1];
    // Oldest two stages, glitch filter on the wide buses
    bus.addr    = addr_r[ADDR_PIPE_DEPTH-1] & addr_r[ADDR_PIPE_DEPTH-2];
    bus.data    = data_r[ADDR_PIPE_DEPTH-1] & data_r[ADDR_PIPE_DEPTH-2];
  end

  ////////////////////////////////////////////////////////////
  // Edges from run patterns
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Long high run, then low in the newest sample
    strobes.rd_start    = (rd_hist == {{(SYNC_DEPTH-3){1'b1}}, 1'b0});
    strobes.rd_end      = (rd_hist == {{(SYNC_DEPTH-3){1'b0}}, 1'b1});
    strobes.wr_end      = (wr_hist == {{(SYNC_DEPTH-3){1'b0}}, 1'b1});
    strobes.cycle_start = (clk_hist == {{(SYNC_DEPTH-5){1'b0}}, 1'b1});  // Rising
    strobes.cycle_end   = (clk_hist == {{(SYNC_DEPTH-5){1'b1}}, 1'b0});  // Falling
  end

endmodule

//--- cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and timing constants
  ////////////////////////////////////////////////////////////

  localparam int SNES_ADDR_W     = 24;
  localparam int ROM_ADDR_W      = 23;  // 16-bit words, so one bit less
  localparam int BYTE_W          = 8;
  localparam int ROM_DATA_W      = 16;
  localparam int SYNC_DEPTH      = 8;   // Strobe oversampling history
  localparam int ADDR_PIPE_DEPTH = 6;
  localparam int DEAD_CNT_W      = 18;

  // Extra cycles an MCU access keeps the PSRAM
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;

  // About 1 ms of low CPU clock at the CLK2 rate
  localparam logic [DEAD_CNT_W-1:0] SNES_DEAD_TIMEOUT = 18'd86000;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ST_IDLE        = 5'b00001,
    ST_MCU_RD_ADDR = 5'b00010,
    ST_MCU_RD_END  = 5'b00100,
    ST_MCU_WR_ADDR = 5'b01000,
    ST_MCU_WR_END  = 5'b10000
  } access_state_e;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mcu_op_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Filtered console bus
  typedef struct packed {
    logic [SNES_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]      data;
    logic                   rd_n;
    logic                   wr_n;
    logic                   cpu_clk;
  } snes_bus_t;

  // One-cycle event pulses
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic cycle_end;
  } snes_strobes_t;

  typedef struct packed {
    logic                   rrq;
    logic                   wrq;
    logic [SNES_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]      wdata;
  } mcu_req_t;

  typedef struct packed {
    logic                   active;
    mcu_op_e                op;
    logic [SNES_ADDR_W-1:0] addr;
  } mcu_grant_t;

  // PSRAM pins, active-low controls
  typedef struct packed {
    logic [ROM_ADDR_W-1:0] addr;
    logic                  we_n;
    logic                  bhe_n;
    logic                  ble_n;
    logic [ROM_DATA_W-1:0] dq_out;
    logic                  dq_oe;
  } rom_bus_t;

endpackage
